//--- design/sound.sv
`timescale 1ns/1ps

module sound (
    input  logic                  fclk,
    input  logic                  reset,
    input  tsconf_pkg::port_cfg_t cfg,
    output logic                  beep
);

    import tsconf_pkg::*;

    logic [PWM_BITS-1:0] pwm_cnt;
    logic                pwm_bit;

    // high for covox counts out of every 256
    assign pwm_bit = pwm_cnt < cfg.covox;

    always_ff @(posedge fclk) begin
        if (reset) begin
            pwm_cnt <= '0;
            beep    <= 1'b0;
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            beep    <= cfg.covox_en ? pwm_bit : cfg.beeper;
        end
    end

endmodule

//--- design/tsconf_io_top.sv
`timescale 1ns/1ps

module tsconf_io_top (
    input  logic        fclk,
    input  logic        reset,
    input  logic        iorq_n,
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        m1_n,
    input  logic [15:0] a,
    input  logic [7:0]  d_in,
    output logic [7:0]  d_out,
    output logic        d_oe,
    output logic        int_n,
    output logic [7:0]  border,
    output logic        beep
);

    import tsconf_pkg::*;

    bus_evt_t   bus;
    port_cfg_t  cfg;
    logic [7:0] ports_data;
    logic       ports_en;
    logic [7:0] im2vect;
    logic       im2vect_en;

    zsignals zsignals (
        .fclk   (fclk),
        .reset  (reset),
        .iorq_n (iorq_n),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .m1_n   (m1_n),
        .a      (a),
        .d_in   (d_in),
        .bus    (bus)
    );

    zports zports (
        .fclk    (fclk),
        .reset   (reset),
        .bus     (bus),
        .cfg     (cfg),
        .rd_data (ports_data),
        .rd_en   (ports_en)
    );

    zint zint (
        .fclk      (fclk),
        .reset     (reset),
        .bus       (bus),
        .cfg       (cfg),
        .int_n     (int_n),
        .vector    (im2vect),
        .vector_en (im2vect_en)
    );

    sound sound (
        .fclk  (fclk),
        .reset (reset),
        .cfg   (cfg),
        .beep  (beep)
    );

    // acknowledge needs m1, so never overlaps a port read
    assign d_out  = im2vect_en ? im2vect : ports_data;
    assign d_oe   = im2vect_en | ports_en;
    assign border = cfg.border;

endmodule

//--- design/tsconf_pkg.sv
package tsconf_pkg;

    // port addresses
    localparam logic [7:0]  PORT_XT      = 8'hAF;
    localparam logic [7:0]  PORT_COVOX   = 8'hFB;
    localparam logic [15:0] PORT_FE_MASK = 16'h0001;

    // beeper bit in a #FE write
    localparam int FE_BEEPER_BIT = 4;

    // extended register file at #xxAF
    localparam logic [7:0] REG_BORDER  = 8'h0F;
    localparam logic [7:0] REG_SNDCONF = 8'h20;
    localparam logic [7:0] REG_IM2V    = 8'h24;
    localparam logic [7:0] REG_INTMASK = 8'h2A;

    localparam int SNDCONF_COVOX_BIT = 0;
    localparam int INT_FRM_BIT       = 0;
    localparam int INT_LIN_BIT       = 1;

    // source codes, vector bits 3..1
    localparam logic [2:0] INT_CODE_FRM = 3'd0;
    localparam logic [2:0] INT_CODE_LIN = 3'd1;

    // interrupt timers, in fclk cycles
    localparam int FRAME_TICKS = 2048;
    localparam int LINE_TICKS  = 224;
    localparam int FRM_CNT_W   = $clog2(FRAME_TICKS);
    localparam int LIN_CNT_W   = $clog2(LINE_TICKS);

    localparam int PWM_BITS = 8;

    typedef struct packed {
        logic [7:0] reg_idx;
        logic [7:0] port;
    } zaddr_s_t;

    // Z80 address, seen as a plain word or as index/port pair
    typedef union packed {
        logic [15:0] raw;
        zaddr_s_t    f;
    } zaddr_u;

    typedef struct packed {
        logic       iord;
        logic       intack;
        logic       iowr_s;
        logic       intack_s;
        zaddr_u     addr;
        logic [7:0] data;
    } bus_evt_t;

    typedef struct packed {
        logic [7:0]          border;
        logic                beeper;
        logic [PWM_BITS-1:0] covox;
        logic                covox_en;
        logic [3:0]          im2v_hi;
        logic [1:0]          intmask;
    } port_cfg_t;

endpackage

//--- design/zint.sv
`timescale 1ns/1ps

module zint (
    input  logic                  fclk,
    input  logic                  reset,
    input  tsconf_pkg::bus_evt_t  bus,
    input  tsconf_pkg::port_cfg_t cfg,
    output logic                  int_n,
    output logic [7:0]            vector,
    output logic                  vector_en
);

    import tsconf_pkg::*;

    logic [FRM_CNT_W-1:0] frm_cnt;
    logic [LIN_CNT_W-1:0] lin_cnt;
    logic                 frm_wrap;
    logic                 lin_wrap;

    logic [1:0] pend;
    logic [1:0] active;
    logic [2:0] live_code;
    logic [2:0] ack_code;

    assign frm_wrap = frm_cnt == FRM_CNT_W'(FRAME_TICKS - 1);
    assign lin_wrap = lin_cnt == LIN_CNT_W'(LINE_TICKS - 1);

    // stand-ins for the video frame and line starts
    always_ff @(posedge fclk) begin
        if (reset) begin
            frm_cnt <= '0;
            lin_cnt <= '0;
        end else begin
            frm_cnt <= frm_wrap ? '0 : frm_cnt + 1'b1;
            lin_cnt <= lin_wrap ? '0 : lin_cnt + 1'b1;
        end
    end

    assign active = pend & cfg.intmask;

    // frame wins over line
    assign live_code = active[INT_FRM_BIT] ? INT_CODE_FRM : INT_CODE_LIN;

    // code is frozen for the whole acknowledge cycle
    always_ff @(posedge fclk) begin
        if (reset) begin
            ack_code <= INT_CODE_FRM;
        end else if (!bus.intack) begin
            ack_code <= live_code;
        end
    end

    // a new wrap beats a clear in the same cycle
    always_ff @(posedge fclk) begin
        if (reset) begin
            pend <= 2'b00;
        end else begin
            if (frm_wrap) begin
                pend[INT_FRM_BIT] <= 1'b1;
            end else if (bus.intack_s && ack_code == INT_CODE_FRM) begin
                pend[INT_FRM_BIT] <= 1'b0;
            end

            if (lin_wrap) begin
                pend[INT_LIN_BIT] <= 1'b1;
            end else if (bus.intack_s && ack_code == INT_CODE_LIN) begin
                pend[INT_LIN_BIT] <= 1'b0;
            end
        end
    end

    assign int_n     = ~|active;
    assign vector    = {cfg.im2v_hi, ack_code, 1'b0};
    assign vector_en = bus.intack;

endmodule

//--- design/zports.sv
`timescale 1ns/1ps

module zports (
    input  logic                  fclk,
    input  logic                  reset,
    input  tsconf_pkg::bus_evt_t  bus,
    output tsconf_pkg::port_cfg_t cfg,
    output logic [7:0]            rd_data,
    output logic                  rd_en
);

    import tsconf_pkg::*;

    logic [7:0] border_r;
    logic       beeper_r;
    logic [7:0] covox_r;
    logic [7:0] sndconf_r;
    logic [7:0] im2v_r;
    logic [7:0] intmask_r;

    logic       fe_hit;
    logic       fb_hit;
    logic       xt_hit;
    logic       idx_known;
    logic [7:0] xt_val;

    // #FE is any port with a0 low
    assign fe_hit = (bus.addr.raw & PORT_FE_MASK) == 16'h0000;
    assign fb_hit = bus.addr.raw[7:0] == PORT_COVOX;
    assign xt_hit = bus.addr.f.port == PORT_XT;

    always_comb begin
        idx_known = 1'b1;
        case (bus.addr.f.reg_idx)
            REG_BORDER:  xt_val = border_r;
            REG_SNDCONF: xt_val = sndconf_r;
            REG_IM2V:    xt_val = im2v_r;
            REG_INTMASK: xt_val = intmask_r;
            default: begin
                idx_known = 1'b0;
                xt_val    = 8'h00;
            end
        endcase
    end

    always_ff @(posedge fclk) begin
        if (reset) begin
            border_r  <= 8'h00;
            beeper_r  <= 1'b0;
            covox_r   <= 8'h00;
            sndconf_r <= 8'h00;
            im2v_r    <= 8'h00;
            intmask_r <= 8'h00;
        end else if (bus.iowr_s) begin
            if (fe_hit) begin
                border_r[2:0] <= bus.data[2:0];
                beeper_r      <= bus.data[FE_BEEPER_BIT];
            end else if (fb_hit) begin
                covox_r <= bus.data;
            end else if (xt_hit) begin
                case (bus.addr.f.reg_idx)
                    REG_BORDER:  border_r  <= bus.data;
                    REG_SNDCONF: sndconf_r <= bus.data;
                    REG_IM2V:    im2v_r    <= bus.data;
                    REG_INTMASK: intmask_r <= bus.data;
                    default: ;
                endcase
            end
        end
    end

    // only known #xxAF registers are claimed on read
    assign rd_en   = bus.iord & xt_hit & idx_known;
    assign rd_data = xt_val;

    always_comb begin
        cfg.border   = border_r;
        cfg.beeper   = beeper_r;
        cfg.covox    = covox_r;
        cfg.covox_en = sndconf_r[SNDCONF_COVOX_BIT];
        cfg.im2v_hi  = im2v_r[7:4];
        cfg.intmask  = intmask_r[INT_LIN_BIT:INT_FRM_BIT];
    end

endmodule

//--- design/zsignals.sv
`timescale 1ns/1ps

module zsignals (
    input  logic                fclk,
    input  logic                reset,
    input  logic                iorq_n,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                m1_n,
    input  logic [15:0]         a,
    input  logic [7:0]          d_in,
    output tsconf_pkg::bus_evt_t bus
);

    // {iorq_n, rd_n, wr_n, m1_n}
    logic [3:0]  ctl_s1;
    logic [3:0]  ctl_s2;
    logic [15:0] a_s1;
    logic [15:0] a_s2;
    logic [7:0]  d_s1;
    logic [7:0]  d_s2;

    logic iorq;
    logic rd;
    logic wr;
    logic m1;

    logic iord;
    logic iowr;
    logic intack;
    logic iowr_d;
    logic intack_d;
    logic iowr_s;
    logic intack_s;

    always_ff @(posedge fclk) begin
        if (reset) begin
            ctl_s1 <= 4'b1111;
            ctl_s2 <= 4'b1111;
        end else begin
            ctl_s1 <= {iorq_n, rd_n, wr_n, m1_n};
            ctl_s2 <= ctl_s1;
        end
    end

    // host holds these stable while strobes are low
    always_ff @(posedge fclk) begin
        a_s1 <= a;
        a_s2 <= a_s1;
        d_s1 <= d_in;
        d_s2 <= d_s1;
    end

    assign iorq = ~ctl_s2[3];
    assign rd   = ~ctl_s2[2];
    assign wr   = ~ctl_s2[1];
    assign m1   = ~ctl_s2[0];

    assign iord   = iorq & rd & ~m1;
    assign iowr   = iorq & wr;
    assign intack = iorq & m1;

    // one-cycle pulses on rising level
    always_ff @(posedge fclk) begin
        if (reset) begin
            iowr_d   <= 1'b0;
            intack_d <= 1'b0;
            iowr_s   <= 1'b0;
            intack_s <= 1'b0;
        end else begin
            iowr_d   <= iowr;
            intack_d <= intack;
            iowr_s   <= iowr & ~iowr_d;
            intack_s <= intack & ~intack_d;
        end
    end

    always_comb begin
        bus.iord     = iord;
        bus.intack   = intack;
        bus.iowr_s   = iowr_s;
        bus.intack_s = intack_s;
        bus.addr.raw = a_s2;
        bus.data     = d_s2;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tsconf_io.f --top-module tsconf_io_tb \
    && out="$(./obj_dir/Vtsconf_io_tb)" \
    && echo "$out" \
    && echo "$out" | grep -qF "PASS: all tests" \
    || { echo "simulation failed"; exit 1; }

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic fclk,
    output logic reset
);

    // 4 ns period
    initial begin
        fclk = 1'b0;
        forever #2 fclk = ~fclk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge fclk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- test/tsconf_io_tb.sv
`timescale 1ns/1ps

module tsconf_io_tb;

    import tsconf_pkg::*;

    localparam int HOLD_CYCLES    = 8;
    localparam int IDLE_CYCLES    = 4;
    // about four frames of tests plus wide margin
    localparam int TIMEOUT_CYCLES = 30000;

    logic        fclk;
    logic        reset;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic [7:0]  d_out;
    logic        d_oe;
    logic        int_n;
    logic [7:0]  border;
    logic        beep;

    int         seed = 65;
    int         err_cnt = 0;
    int         check_cnt = 0;
    int         test_cnt = 0;
    int         cycle_cnt = 0;
    logic [7:0] border_exp;
    logic [7:0] im2v_val;

    tb_clock clk_gen (
        .fclk  (fclk),
        .reset (reset)
    );

    tsconf_io_top dut_i (
        .fclk   (fclk),
        .reset  (reset),
        .iorq_n (iorq_n),
        .rd_n   (rd_n),
        .wr_n   (wr_n),
        .m1_n   (m1_n),
        .a      (a),
        .d_in   (d_in),
        .d_out  (d_out),
        .d_oe   (d_oe),
        .int_n  (int_n),
        .border (border),
        .beep   (beep)
    );

    always @(posedge fclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic logic [7:0] rand_byte();
        return 8'($random(seed));
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        check_cnt++;
        assert (got == exp) else begin
            $display("[FAIL] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int start);
        test_cnt++;
        if (err_cnt == start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - start);
        end
    endtask

    // one Z80 cycle, held 8 clocks, sampled in the last held clock
    task automatic bus_cycle(input logic rd, input logic wr, input logic m1,
                             input logic [15:0] addr, input logic [7:0] data,
                             output logic [7:0] got_d, output logic got_oe);
        @(posedge fclk);
        #1;
        a      = addr;
        d_in   = data;
        iorq_n = 1'b0;
        rd_n   = ~rd;
        wr_n   = ~wr;
        m1_n   = ~m1;
        repeat (HOLD_CYCLES - 1) @(posedge fclk);
        #1;
        got_d  = d_out;
        got_oe = d_oe;
        @(posedge fclk);
        #1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        m1_n   = 1'b1;
        repeat (IDLE_CYCLES) @(posedge fclk);
        #1;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused_d;
        logic       unused_oe;
        bus_cycle(1'b0, 1'b1, 1'b0, addr, data, unused_d, unused_oe);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [7:0] got_d,
                           output logic got_oe);
        bus_cycle(1'b1, 1'b0, 1'b0, addr, 8'h00, got_d, got_oe);
    endtask

    task automatic int_ack(output logic [7:0] got_d, output logic got_oe);
        bus_cycle(1'b0, 1'b0, 1'b1, 16'hFFFF, 8'h00, got_d, got_oe);
    endtask

    task automatic wait_int_low(input int limit, output int waited);
        waited = 0;
        while (int_n !== 1'b0 && waited < limit) begin
            @(posedge fclk);
            #1;
            waited++;
        end
        assert (int_n === 1'b0) else begin
            $display("error at %0t ns: int_n did not go low within %0d cycles", $time, limit);
            err_cnt++;
        end
    endtask

    task automatic fe_port_test();
        int          start;
        int          i;
        logic [7:0]  val;
        logic [15:0] addr;
        start = err_cnt;
        check_val("int_n after reset", int'(int_n), 1);
        check_val("d_oe after reset", int'(d_oe), 0);
        check_val("beep after reset", int'(beep), 0);
        for (i = 0; i < 4; i++) begin
            val = rand_byte();
            val[FE_BEEPER_BIT] = ~i[0];
            // odd high byte, a0 low
            addr = {rand_byte() | 8'h01, rand_byte() & 8'hFE};
            io_write(addr, val);
            border_exp[2:0] = val[2:0];
            check_val($sformatf("border after #FE write to %04h", addr),
                      int'(border), int'(border_exp));
            check_val("beep follows beeper bit", int'(beep), int'(val[FE_BEEPER_BIT]));
        end
        report_test("port fe write", start);
    endtask

    task automatic xt_roundtrip(input logic [7:0] idx);
        int         i;
        logic [7:0] val;
        logic [7:0] got;
        logic       oe;
        for (i = 0; i < 3; i++) begin
            val = rand_byte();
            io_write({idx, PORT_XT}, val);
            io_read({idx, PORT_XT}, got, oe);
            check_val($sformatf("reg %02h read enable", idx), int'(oe), 1);
            check_val($sformatf("reg %02h read data", idx), int'(got), int'(val));
            if (idx == REG_BORDER) begin
                border_exp = val;
                check_val("full border output", int'(border), int'(border_exp));
            end
        end
    endtask

    task automatic xt_reg_test();
        int         start;
        logic [7:0] got;
        logic       oe;
        start = err_cnt;
        xt_roundtrip(REG_BORDER);
        xt_roundtrip(REG_SNDCONF);
        xt_roundtrip(REG_IM2V);
        xt_roundtrip(REG_INTMASK);
        io_read({8'h55, PORT_XT}, got, oe);
        check_val("unknown index 55 claimed", int'(oe), 0);
        io_read({8'h00, PORT_XT}, got, oe);
        check_val("unknown index 00 claimed", int'(oe), 0);
        io_read({REG_BORDER, PORT_COVOX}, got, oe);
        check_val("read of #FB claimed", int'(oe), 0);
        io_read({REG_BORDER, 8'hFE}, got, oe);
        check_val("read of #FE claimed", int'(oe), 0);
        io_write({REG_SNDCONF, PORT_XT}, 8'h00);
        io_write({REG_INTMASK, PORT_XT}, 8'h00);
        report_test("extended registers", start);
    endtask

    task automatic covox_test();
        int         start;
        int         i;
        int         j;
        int         ones;
        logic [7:0] sample;
        start = err_cnt;
        io_write({REG_SNDCONF, PORT_XT}, 8'(1 << SNDCONF_COVOX_BIT));
        for (i = 0; i < 5; i++) begin
            case (i)
                0: sample = 8'h00;
                1: sample = 8'hFF;
                default: sample = rand_byte();
            endcase
            io_write({rand_byte(), PORT_COVOX}, sample);
            ones = 0;
            for (j = 0; j < 256; j++) begin
                if (beep) begin
                    ones++;
                end
                @(posedge fclk);
                #1;
            end
            check_val($sformatf("covox %02h high cycles", sample), ones, int'(sample));
        end
        io_write({REG_SNDCONF, PORT_XT}, 8'h00);
        report_test("covox pwm", start);
    endtask

    task automatic frame_int_test();
        int         start;
        int         waited;
        logic [7:0] got;
        logic       oe;
        start = err_cnt;
        im2v_val = rand_byte();
        io_write({REG_IM2V, PORT_XT}, im2v_val);
        io_write({REG_INTMASK, PORT_XT}, 8'(1 << INT_FRM_BIT));
        // may be a frame left pending by earlier tests
        wait_int_low(FRAME_TICKS + 16, waited);
        int_ack(got, oe);
        check_val("frame ack d_oe", int'(oe), 1);
        check_val("frame vector", int'(got), int'({im2v_val[7:4], INT_CODE_FRM, 1'b0}));
        check_val("int_n after frame ack", int'(int_n), 1);
        wait_int_low(FRAME_TICKS + 16, waited);
        int_ack(got, oe);
        check_val("fresh frame vector", int'(got),
                  int'({im2v_val[7:4], INT_CODE_FRM, 1'b0}));
        // acked just after a wrap, next one is almost a full frame away
        wait_int_low(FRAME_TICKS + 16, waited);
        assert (waited >= FRAME_TICKS - 32 && waited <= FRAME_TICKS) else begin
            $display("[FAIL] %0t ns: int_n came back after %0d cycles, not about one frame",
                     $time, waited);
            err_cnt++;
        end
        io_write({REG_INTMASK, PORT_XT}, 8'h00);
        report_test("frame interrupt", start);
    endtask

    task automatic priority_test();
        int         start;
        int         i;
        logic       high_ok;
        logic [7:0] got;
        logic       oe;
        start = err_cnt;
        high_ok = 1'b1;
        for (i = 0; i < FRAME_TICKS + 64; i++) begin
            if (int_n !== 1'b1) begin
                high_ok = 1'b0;
            end
            @(posedge fclk);
            #1;
        end
        assert (high_ok) else begin
            $display("[FAIL] %0t ns: int_n went low with all sources masked", $time);
            err_cnt++;
        end
        io_write({REG_INTMASK, PORT_XT}, 8'((1 << INT_FRM_BIT) | (1 << INT_LIN_BIT)));
        check_val("int_n with both pending", int'(int_n), 0);
        int_ack(got, oe);
        check_val("first vector", int'(got), int'({im2v_val[7:4], INT_CODE_FRM, 1'b0}));
        int_ack(got, oe);
        check_val("second vector", int'(got), int'({im2v_val[7:4], INT_CODE_LIN, 1'b0}));
        io_write({REG_INTMASK, PORT_XT}, 8'h00);
        report_test("priority and masking", start);
    endtask

    initial begin
        iorq_n     = 1'b1;
        rd_n       = 1'b1;
        wr_n       = 1'b1;
        m1_n       = 1'b1;
        a          = 16'h0000;
        d_in       = 8'h00;
        border_exp = 8'h00;
        im2v_val   = 8'h00;
        @(negedge reset);
        @(posedge fclk);
        #1;

        fe_port_test();
        xt_reg_test();
        covox_test();
        frame_int_test();
        priority_test();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- tsconf_io.f
design/tsconf_pkg.sv
design/zsignals.sv
design/zports.sv
design/zint.sv
design/sound.sv
design/tsconf_io_top.sv
test/tb_clock.sv
test/tsconf_io_tb.sv
